//--- bench/ringL1Bench.sv
// drives requests on the falling edge; loads only hit words written earlier, as reset leaves stores undefined
module ringL1Bench;
	timeunit 1ns;
	timeprecision 1ps;
	import ringPkg::*;

	localparam int clockPeriod = 10;
	localparam int resetCycles = 2;
	localparam int randomCount = 64;
	localparam int streamCount = 200;	// pushes the sequence number past 256
	localparam int watchMargin = 32;
	localparam int slotCount = nodeCount * wordsPerNode;

	localparam logic [dataWidth-1:0] wordA = 64'h0123_4567_89AB_CDEF;
	localparam logic [dataWidth-1:0] wordB = 64'hFEDC_BA98_7654_3210;
	localparam logic [dataWidth-1:0] wordC = 64'hA5A5_5A5A_0F0F_F0F0;
	localparam logic [dataWidth-1:0] wordD = 64'h8000_0000_0000_0001;
	localparam logic [dataWidth-1:0] wordE = 64'h1357_9BDF_2468_ACE0;
	localparam logic [dataWidth-1:0] wordF = 64'hDEAD_BEEF_CAFE_F00D;

	typedef struct packed
	{
		hostReq req;
		ringOp expOp;
		logic [dataWidth-1:0] expData;
	} stepEntry;

	logic clock;
	logic reset;
	logic reqValid;
	hostReq req;
	logic respValid;
	hostResp resp;

	int cycleCount = 0;
	int watchLimit = 0;
	logic [seqWidth-1:0] seqExpected = '0;

	stepEntry steps[$];
	string stepNames[$];

	// outstanding responses in request order
	hostResp expQ[$];
	string expNames[$];
	int expDue[$];

	logic [dataWidth-1:0] modelStore [slotCount];
	bit known [slotCount];	// word written at least once

	ringL1Top dut
	(
		.clock(clock),
		.reset(reset),
		.reqValid(reqValid),
		.req(req),
		.respValid(respValid),
		.resp(resp)
	);

	always #(clockPeriod / 2) clock = ~clock;

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
	end

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1, "run stopped at the first failed check");
	endtask

	task automatic checkField(input string name, input string field,
		input logic [63:0] expected, input logic [63:0] actual);
		assert (actual === expected)
		else failRun($sformatf("[ERROR] %s %s expected %0h actual %0h",
			name, field, expected, actual));
	endtask

	task automatic addStep(input string name, input ringOp op, input logic [addrWidth-1:0] addr,
		input logic [dataWidth-1:0] data, input ringOp expOp, input logic [dataWidth-1:0] expData);
		stepEntry s;
		s.req.op = op;
		s.req.addr = addr;
		s.req.data = data;
		s.expOp = expOp;
		s.expData = expData;
		steps.push_back(s);
		stepNames.push_back(name);
	endtask

	task automatic buildTable();
		addStep("storeNode0", opStore, 8'h03, wordA, opStoreDone, wordA);
		addStep("storeNode1", opStore, 8'h17, wordB, opStoreDone, wordB);
		addStep("storeNode2", opStore, 8'h2A, wordC, opStoreDone, wordC);
		addStep("storeNode3", opStore, 8'h3F, wordD, opStoreDone, wordD);
		addStep("loadNode0", opLoad, 8'h03, '0, opLoadDone, wordA);
		addStep("loadNode1", opLoad, 8'h17, '0, opLoadDone, wordB);
		addStep("idleGap", opIdle, 8'h00, '0, opIdle, '0);
		addStep("loadNode2", opLoad, 8'h2A, '0, opLoadDone, wordC);
		addStep("loadNode3", opLoad, 8'h3F, '0, opLoadDone, wordD);
		addStep("swapNode1", opSwap, 8'h17, wordE, opSwapDone, wordB);	// old word back
		addStep("loadAfterSwap", opLoad, 8'h17, '0, opLoadDone, wordE);
		addStep("storeWord14", opStore, 8'h0E, wordF, opStoreDone, wordF);
		addStep("unmappedStore", opStore, 8'h4E, wordA, opFault, '0);
		addStep("unmappedLoad", opLoad, 8'h9E, '0, opFault, '0);
		addStep("unmappedSwap", opSwap, 8'hFE, wordB, opFault, '0);
		addStep("idleGap", opIdle, 8'h00, '0, opIdle, '0);
		addStep("idleGap", opIdle, 8'h00, '0, opIdle, '0);
		// unmapped store above must have left this word alone
		addStep("loadWord14", opLoad, 8'h0E, '0, opLoadDone, wordF);
		addStep("swapBackToBack", opSwap, 8'h03, wordC, opSwapDone, wordA);
		addStep("loadBackToBack", opLoad, 8'h03, '0, opLoadDone, wordC);
	endtask

	function automatic bit isMapped(logic [addrWidth-1:0] addr);
		return int'(addr[addrWidth-1 -: nodeFieldWidth]) < nodeCount;
	endfunction

	function automatic int slotOf(logic [addrWidth-1:0] addr);
		return int'(addr[addrWidth-1 -: nodeFieldWidth]) * wordsPerNode
			+ int'(addr[wordIndexWidth-1:0]);
	endfunction

	// reference model, also updates the store copy
	function automatic hostResp predictResponse(hostReq r);
		hostResp e;
		int slot;
		e.op = opFault;
		e.seq = seqExpected;
		e.addr = r.addr;
		e.data = '0;
		e.excCode = faultNoResponder;
		if (isMapped(r.addr))
		begin
			slot = slotOf(r.addr);
			e.excCode = '0;
			case (r.op)
				opLoad:
				begin
					e.op = opLoadDone;
					e.data = modelStore[slot];
				end
				opStore:
				begin
					e.op = opStoreDone;
					e.data = r.data;
					modelStore[slot] = r.data;
					known[slot] = 1'b1;
				end
				default:
				begin
					e.op = opSwapDone;
					e.data = modelStore[slot];	// previous word
					modelStore[slot] = r.data;
				end
			endcase
		end
		return e;
	endfunction

	task automatic issueRequest(input string name, input hostReq r, input hostResp expected);
		@(negedge clock);
		reqValid = 1'b1;
		req = r;
		expQ.push_back(expected);
		expNames.push_back(name);
		expDue.push_back(cycleCount + ringLatency);
		seqExpected = seqExpected + 1'b1;
	endtask

	task automatic idleCycle();
		@(negedge clock);
		reqValid = 1'b0;
		req = '0;
	endtask

	// outputs are stable at the falling edge
	always @(negedge clock)
	begin
		hostResp exp;
		string name;
		int due;
		if (!reset)
		begin
			if (respValid)
			begin
				assert (expQ.size() > 0)
				else failRun("a response came out with no request outstanding");
				exp = expQ.pop_front();
				name = expNames.pop_front();
				due = expDue.pop_front();
				checkField(name, "cycle", 64'(due), 64'(cycleCount));
				checkField(name, "op", 64'(exp.op), 64'(resp.op));
				checkField(name, "seq", 64'(exp.seq), 64'(resp.seq));
				checkField(name, "addr", 64'(exp.addr), 64'(resp.addr));
				checkField(name, "data", exp.data, resp.data);
				checkField(name, "excCode", 64'(exp.excCode), 64'(resp.excCode));
			end
			else
			begin
				assert (expQ.size() == 0 || expDue[0] > cycleCount)
				else failRun($sformatf("no response for %s by its due cycle", expNames[0]));
			end
		end
	end

	initial
	begin
		wait (watchLimit > 0);
		#(watchLimit * clockPeriod);
		failRun($sformatf("timeout, the run was still busy after %0d cycles", watchLimit));
	end

	initial
	begin
		hostReq r;
		hostResp expected;
		int unsigned pick;
		void'($urandom(21776));
		clock = 1'b0;
		reset = 1'b1;
		reqValid = 1'b0;
		req = '0;
		buildTable();
		watchLimit = resetCycles + steps.size() + 2 * randomCount + streamCount
			+ ringLatency + watchMargin;	// random phase may idle once per request
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// directed table, one entry per cycle
		foreach (steps[i])
		begin
			if (steps[i].req.op == opIdle)
			begin
				idleCycle();
			end
			else
			begin
				expected = predictResponse(steps[i].req);	// keeps the store copy in step
				expected.op = steps[i].expOp;
				expected.data = steps[i].expData;
				expected.excCode = (steps[i].expOp == opFault) ? faultNoResponder : '0;
				issueRequest(stepNames[i], steps[i].req, expected);
			end
		end

		// random traffic, node fields 4 and 5 unmapped
		for (int n = 0; n < randomCount; n++)
		begin
			if ($urandom_range(3) == 0)
			begin
				idleCycle();
			end
			pick = $urandom_range(2);
			r.addr = addrWidth'($urandom_range(95));
			r.data = {$urandom, $urandom};
			case (pick)
				0: r.op = opLoad;
				1: r.op = opStore;
				default: r.op = opSwap;
			endcase
			if (isMapped(r.addr) && !known[slotOf(r.addr)])
			begin
				r.op = opStore;	// never read an undefined word
			end
			expected = predictResponse(r);
			issueRequest($sformatf("random%0d", n), r, expected);
		end

		// back-to-back store and load pairs across every word
		for (int n = 0; n < streamCount; n++)
		begin
			r.addr = addrWidth'((n / 2) % slotCount);
			r.op = (n % 2 == 0) ? opStore : opLoad;
			r.data = {32'(n), $urandom};
			expected = predictResponse(r);
			issueRequest($sformatf("stream%0d", n), r, expected);
		end

		idleCycle();
		while (expQ.size() > 0)
		begin
			@(negedge clock);
		end
		repeat (ringLatency + 2) @(negedge clock);	// nothing more may come out
		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- bench/ringL1_checker.sv
// bound into ringL1Top; latency check assumes the fixed pipeline with requests driven low in reset
module ringL1Checker
(
	input logic clock,
	input logic reset,
	input logic reqValid,
	input logic respValid,
	input ringPkg::hostResp resp
);
	timeunit 1ns;
	timeprecision 1ps;
	import ringPkg::*;

	// quiet output while reset holds and on the edge after
	resetQuiet: assert property (@(posedge clock) reset |=> !respValid)
		else $error("respValid high during or right after reset");

	// every accepted request comes out exactly ringLatency cycles later
	fixedLatency: assert property (@(posedge clock) disable iff (reset)
		respValid == $past(reqValid, ringLatency))
		else $error("respValid does not follow reqValid by the ring latency");

	faultCritical: assert property (@(posedge clock)
		(respValid && resp.op == opFault) |-> resp.excCode[15])
		else $error("fault response without the critical bit in excCode");

endmodule

bind ringL1Top ringL1Checker respCheck
(
	.clock(clock),
	.reset(reset),
	.reqValid(reqValid),
	.respValid(respValid),
	.resp(resp)
);

//--- flist.f
verilog/ringPkg.sv
verilog/ringInjector.sv
verilog/ringMemNode.sv
verilog/ringCollector.sv
verilog/ringL1Top.sv
bench/ringL1_checker.sv
bench/ringL1Bench.sv

//--- run.sh
#!/bin/sh
# Verilator 5 or later is needed for --binary and --timing

cd "$(dirname "$0")" || exit 1

logFile=sim.log
simName=ringSim

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f flist.f --top-module ringL1Bench -o "$simName"
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
	echo "build failed with status $buildStatus"
	exit 1
fi

./obj_dir/"$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "Finished with errors" "$logFile"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ "$simStatus" -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi
echo "simulation passed"
exit 0

//--- verilog/ringCollector.sv
// ring exit stage; any request that reaches it unserved leaves as a fault with data cleared
module ringCollector
(
	input logic clock,
	input logic reset,
	input ringPkg::ringMsg ringIn,
	output logic respValid,
	output ringPkg::hostResp resp
);
	import ringPkg::*;

	logic slotBusy;
	logic unserved;
	hostResp nextResp;

	assign slotBusy = (ringIn.op != opIdle);

	// still a request opcode means no node owned the address
	assign unserved = isRequest(ringIn.op);

	always_comb
	begin
		nextResp.op = ringIn.op;
		nextResp.seq = ringIn.seq;
		nextResp.addr = ringIn.addr;
		nextResp.data = ringIn.data;
		nextResp.excCode = '0;	// done responses carry no exception
		if (unserved)
		begin
			nextResp.op = opFault;
			nextResp.data = '0;
			nextResp.excCode = faultNoResponder;
		end
	end

	// host response register
	always_ff @(posedge clock)
	begin
		resp <= nextResp;
		respValid <= slotBusy;	// one cycle per message
		if (reset)
		begin
			respValid <= 1'b0;
			resp.op <= opIdle;
		end
	end

endmodule

//--- verilog/ringInjector.sv
// ring entry stage; every cycle with reqValid high is accepted, sequence numbers wrap at 256
module ringInjector
(
	input logic clock,
	input logic reset,
	input logic reqValid,
	input ringPkg::hostReq req,
	output ringPkg::ringMsg ringOut
);
	import ringPkg::*;

	logic [seqWidth-1:0] seqCount;	// tag for the next accepted request
	ringMsg nextMsg;

	// build the slot for stage 0
	always_comb
	begin
		nextMsg.op = opIdle;
		nextMsg.seq = seqCount;
		nextMsg.addr = req.addr;
		nextMsg.data = req.data;
		if (reqValid)
		begin
			nextMsg.op = req.op;
		end
	end

	// sequence counter, wraps on its own width
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			seqCount <= '0;
		end
		else if (reqValid)
		begin
			seqCount <= seqCount + 1'b1;
		end
	end

	// payload follows every cycle, only the opcode is cleared
	always_ff @(posedge clock)
	begin
		ringOut <= nextMsg;
		if (reset)
		begin
			ringOut.op <= opIdle;
		end
	end

endmodule

//--- verilog/ringL1Top.sv
// ring subsystem top; fixed latency of ringLatency cycles with strict request order
module ringL1Top
(
	input logic clock,
	input logic reset,
	input logic reqValid,
	input ringPkg::hostReq req,
	output logic respValid,
	output ringPkg::hostResp resp
);
	import ringPkg::*;

	// stage 0 from the injector, stage nodeCount into the collector
	ringMsg ringStage [0:nodeCount];

	ringInjector injector
	(
		.clock(clock),
		.reset(reset),
		.reqValid(reqValid),
		.req(req),
		.ringOut(ringStage[0])
	);

	// one stop per region, told apart by nodeIndex
	for (genvar i = 0; i < nodeCount; i++)
	begin : genNode
		ringMemNode #(
			.nodeIndex(i)
		) node
		(
			.clock(clock),
			.reset(reset),
			.ringIn(ringStage[i]),
			.ringOut(ringStage[i+1])
		);
	end

	ringCollector collector
	(
		.clock(clock),
		.reset(reset),
		.ringIn(ringStage[nodeCount]),
		.respValid(respValid),
		.resp(resp)
	);

endmodule

//--- verilog/ringMemNode.sv
// one ring stop; serves its own node field from a 16-word store that reset does not clear
module ringMemNode #(
	parameter int nodeIndex = 0	// region owned by this stop
)
(
	input logic clock,
	input logic reset,
	input ringPkg::ringMsg ringIn,
	output ringPkg::ringMsg ringOut
);
	import ringPkg::*;

	logic [nodeFieldWidth-1:0] nodeField;
	logic [wordIndexWidth-1:0] wordIndex;
	logic ownsAddr;
	logic serve;
	logic writeEnable;
	logic [dataWidth-1:0] oldWord;
	logic [dataWidth-1:0] storeWords [wordsPerNode];
	ringMsg nextMsg;

	// address split into region and word
	assign nodeField = ringIn.addr[addrWidth-1 -: nodeFieldWidth];
	assign wordIndex = ringIn.addr[wordIndexWidth-1:0];

	assign ownsAddr = (nodeField == nodeFieldWidth'(nodeIndex));

	// responses from earlier stops are never touched
	assign serve = ownsAddr && isRequest(ringIn.op);

	// store and swap both write the new word
	assign writeEnable = serve && ((ringIn.op == opStore) || (ringIn.op == opSwap));

	assign oldWord = storeWords[wordIndex];	// value before this cycle's write

	always_comb
	begin
		nextMsg = ringIn;	// default is plain forwarding
		if (serve)
		begin
			nextMsg.op = doneCode(ringIn.op);
			case (ringIn.op)
				opLoad: nextMsg.data = oldWord;
				opStore: nextMsg.data = ringIn.data;	// echo what was written
				opSwap: nextMsg.data = oldWord;	// old word goes back
				default: nextMsg.data = ringIn.data;
			endcase
		end
	end

	// scratch store, write lands at the clock edge
	always_ff @(posedge clock)
	begin
		if (writeEnable)
		begin
			storeWords[wordIndex] <= ringIn.data;
		end
	end

	// next ring stage
	always_ff @(posedge clock)
	begin
		ringOut <= nextMsg;
		if (reset)
		begin
			ringOut.op <= opIdle;	// empty ring after reset
		end
	end

endmodule

//--- verilog/ringPkg.sv
// ring types and sizing; 8-bit addresses with a 4-bit node field, no handshake or back-pressure
package ringPkg;

	// ring geometry
	localparam int nodeCount = 4;
	localparam int wordsPerNode = 16;
	localparam int addrWidth = 8;
	localparam int dataWidth = 64;
	localparam int seqWidth = 8;
	localparam int excWidth = 16;

	localparam int wordIndexWidth = $clog2(wordsPerNode);	// low address bits
	localparam int nodeFieldWidth = addrWidth - wordIndexWidth;	// high address bits

	// injector + one stage per node + collector
	localparam int ringLatency = nodeCount + 2;

	// bit 15 set marks a critical fault
	localparam logic [excWidth-1:0] faultNoResponder = 16'h8001;

	typedef enum logic [2:0]
	{
		opIdle = 3'd0,	// empty slot
		opLoad = 3'd1,
		opStore = 3'd2,
		opSwap = 3'd3,
		opLoadDone = 3'd4,
		opStoreDone = 3'd5,
		opSwapDone = 3'd6,
		opFault = 3'd7	// nobody served it
	} ringOp;

	typedef struct packed
	{
		ringOp op;
		logic [addrWidth-1:0] addr;
		logic [dataWidth-1:0] data;
	} hostReq;

	typedef struct packed
	{
		ringOp op;
		logic [seqWidth-1:0] seq;
		logic [addrWidth-1:0] addr;
		logic [dataWidth-1:0] data;
	} ringMsg;

	typedef struct packed
	{
		ringOp op;
		logic [seqWidth-1:0] seq;
		logic [addrWidth-1:0] addr;
		logic [dataWidth-1:0] data;
		logic [excWidth-1:0] excCode;
	} hostResp;

	// true for the three request opcodes
	function automatic logic isRequest(ringOp op);
		return op inside {opLoad, opStore, opSwap};
	endfunction

	// request opcode to its response opcode
	function automatic ringOp doneCode(ringOp op);
		case (op)
			opLoad: return opLoadDone;
			opStore: return opStoreDone;
			opSwap: return opSwapDone;
			default: return op;
		endcase
	endfunction

endpackage
